// ==== src.f ====
hw/core_pkg.sv
hw/register_file.sv
hw/alu_unit.sv
hw/mul_pipeline.sv
hw/reorder_buffer.sv
hw/decode_issue.sv
hw/core_top.sv
bench/tb_clock.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

// ==== bench/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;

    localparam int ROB_DEPTH = 10;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT = 7'b0100000;
    localparam logic [6:0] F7_MUL = 7'b0000001;

    logic clk;
    logic reset;
    logic inst_valid;
    core_pkg::inst_u inst_data;
    logic inst_ready;
    logic commit_valid;
    core_pkg::commit_t commit_data;
    logic commit_ready;

    logic [core_pkg::XLEN-1:0] model_regs [32];
    core_pkg::commit_t expected_q [$];
    core_pkg::commit_t held_data;
    logic held_valid;
    int errors;
    int checks;
    int sent;
    bit sending_done;

    tb_clock u_clock (
        .clk  (clk),
        .reset(reset)
    );

    core_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst_data   (inst_data),
        .inst_ready  (inst_ready),
        .commit_valid(commit_valid),
        .commit_data (commit_data),
        .commit_ready(commit_ready)
    );

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic check_commit(input string name, input core_pkg::commit_t actual,
                                input core_pkg::commit_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: got rd=%h value=%h, expected rd=%h value=%h at %0t",
                     name, actual.rd, actual.value, expected.rd, expected.value, $time);
        end
    endtask

    function automatic core_pkg::inst_u enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] funct3,
                                              input logic [4:0] rd);
        core_pkg::inst_u w;
        w.r.funct7 = funct7;
        w.r.rs2 = rs2;
        w.r.rs1 = rs1;
        w.r.funct3 = funct3;
        w.r.rd = rd;
        w.r.opcode = core_pkg::OPCODE_OP;
        return w;
    endfunction

    function automatic core_pkg::inst_u enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] funct3, input logic [4:0] rd);
        core_pkg::inst_u w;
        w.i.imm = imm;
        w.i.rs1 = rs1;
        w.i.funct3 = funct3;
        w.i.rd = rd;
        w.i.opcode = core_pkg::OPCODE_OP_IMM;
        return w;
    endfunction

    // Architectural result of one word in program order
    task automatic model_accept(input core_pkg::inst_u w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0] sh;
        logic is_op;
        logic keep;
        core_pkg::commit_t exp;
        is_op = w.r.opcode == core_pkg::OPCODE_OP;
        keep = is_op || w.r.opcode == core_pkg::OPCODE_OP_IMM;
        a = model_regs[w.r.rs1];
        b = is_op ? model_regs[w.r.rs2] : {{20{w.i.imm[11]}}, w.i.imm};
        sh = b[4:0];
        res = '0;
        if (is_op && w.r.funct7 == F7_MUL) begin
            if (w.r.funct3 == 3'b000) begin
                res = 32'(longint'(a) * longint'(b));
            end else begin
                keep = 1'b0;
            end
        end else begin
            case (w.r.funct3)
                3'b000: res = (is_op && w.r.funct7[5]) ? a - b : a + b;
                3'b001: res = a << sh;
                3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011: res = (a < b) ? 32'd1 : 32'd0;
                3'b100: res = a ^ b;
                3'b101: begin
                    // Bit 30 picks arithmetic shift in both formats
                    if (w.r.funct7[5]) begin
                        res = $signed(a) >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
                3'b110: res = a | b;
                default: res = a & b;
            endcase
        end
        if (keep) begin
            exp.rd = w.r.rd;
            exp.value = res;
            expected_q.push_back(exp);
            if (w.r.rd != 5'd0) begin
                model_regs[w.r.rd] = res;
            end
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_inst(input core_pkg::inst_u word);
        inst_valid = 1'b1;
        inst_data = word;
        @(posedge clk);
        while (!inst_ready) @(posedge clk);
        sent++;
        model_accept(word);
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic drain_commits();
        while (expected_q.size() != 0) @(negedge clk);
        // Extra cycles so a stray commit would still be caught
        repeat (4) @(negedge clk);
        check_bit("commit_valid", commit_valid, 1'b0);
    endtask

    function automatic core_pkg::inst_u random_inst();
        logic [4:0] rd;
        logic [4:0] ra;
        logic [4:0] rb;
        rd = 5'($urandom_range(8, 1));
        ra = 5'($urandom_range(8, 0));
        rb = 5'($urandom_range(8, 0));
        case ($urandom_range(5, 0))
            0: return enc_r(F7_BASE, rb, ra, 3'b000, rd);
            1: return enc_r(F7_ALT, rb, ra, 3'b000, rd);
            2: return enc_r(F7_BASE, rb, ra, 3'b100, rd);
            3: return enc_r(F7_MUL, rb, ra, 3'b000, rd);
            4: return enc_i(12'($urandom_range(4095, 0)), ra, 3'b000, rd);
            default: return enc_i({F7_ALT, 5'($urandom_range(31, 0))}, ra, 3'b101, rd);
        endcase
    endfunction

    task automatic test_reset();
        // Supported word with valid low, so inst_ready shows the buffer state
        inst_data = enc_r(F7_BASE, 5'd2, 5'd1, 3'b000, 5'd3);
        @(posedge clk);
        check_bit("commit_valid", commit_valid, 1'b0);
        check_bit("inst_ready", inst_ready, 1'b1);
        @(negedge clk);
    endtask

    task automatic test_alu_ops();
        core_pkg::inst_u foreign;
        send_inst(enc_i(12'hffb, 5'd0, 3'b000, 5'd1));
        send_inst(enc_i(12'h123, 5'd0, 3'b000, 5'd2));
        send_inst(enc_i(12'h007, 5'd0, 3'b000, 5'd3));
        send_inst(enc_i(12'h014, 5'd2, 3'b001, 5'd4));
        send_inst(enc_r(F7_BASE, 5'd2, 5'd1, 3'b000, 5'd5));
        send_inst(enc_r(F7_ALT, 5'd1, 5'd2, 3'b000, 5'd6));
        send_inst(enc_r(F7_BASE, 5'd2, 5'd1, 3'b111, 5'd7));
        send_inst(enc_r(F7_BASE, 5'd2, 5'd1, 3'b110, 5'd8));
        send_inst(enc_r(F7_BASE, 5'd2, 5'd1, 3'b100, 5'd9));
        send_inst(enc_r(F7_BASE, 5'd2, 5'd1, 3'b010, 5'd10));
        send_inst(enc_r(F7_BASE, 5'd2, 5'd1, 3'b011, 5'd11));
        send_inst(enc_r(F7_BASE, 5'd3, 5'd2, 3'b001, 5'd12));
        send_inst(enc_r(F7_BASE, 5'd3, 5'd1, 3'b101, 5'd13));
        send_inst(enc_r(F7_ALT, 5'd3, 5'd1, 3'b101, 5'd14));
        send_inst(enc_i(12'hfff, 5'd1, 3'b100, 5'd15));
        send_inst(enc_i(12'h0f0, 5'd2, 3'b110, 5'd16));
        send_inst(enc_i(12'h7f0, 5'd1, 3'b111, 5'd17));
        send_inst(enc_i(12'hffd, 5'd1, 3'b010, 5'd18));
        send_inst(enc_i(12'hfff, 5'd2, 3'b011, 5'd19));
        send_inst(enc_i(12'h01c, 5'd1, 3'b101, 5'd20));
        send_inst(enc_i(12'h401, 5'd1, 3'b101, 5'd21));
        send_inst(enc_i(12'h800, 5'd1, 3'b000, 5'd22));
        // Shift amount from a register with high bits set
        send_inst(enc_r(F7_BASE, 5'd1, 5'd2, 3'b001, 5'd25));
        // x0 write commits but the register stays zero
        send_inst(enc_i(12'h005, 5'd2, 3'b000, 5'd0));
        send_inst(enc_r(F7_BASE, 5'd3, 5'd0, 3'b000, 5'd23));
        foreign = 32'h0000_0073;
        send_inst(foreign);
        foreign = 32'h0040_a303;
        send_inst(foreign);
        // DIV is not supported and is dropped
        send_inst(enc_r(F7_MUL, 5'd3, 5'd2, 3'b100, 5'd24));
        send_inst(enc_i(12'h001, 5'd0, 3'b000, 5'd24));
        drain_commits();
    endtask

    task automatic test_mul_order();
        send_inst(enc_r(F7_MUL, 5'd2, 5'd1, 3'b000, 5'd26));
        for (int i = 0; i < 4; i++) begin
            send_inst(enc_i(12'(i * 11 + 3), 5'd3, 3'b000, 5'(27 + i)));
        end
        send_inst(enc_r(F7_MUL, 5'd1, 5'd1, 3'b000, 5'd28));
        send_inst(enc_r(F7_MUL, 5'd1, 5'd4, 3'b000, 5'd29));
        send_inst(enc_r(F7_MUL, 5'd4, 5'd4, 3'b000, 5'd31));
        send_inst(enc_r(F7_BASE, 5'd3, 5'd2, 3'b110, 5'd30));
        drain_commits();
    endtask

    task automatic test_dependencies();
        send_inst(enc_r(F7_MUL, 5'd3, 5'd1, 3'b000, 5'd5));
        send_inst(enc_r(F7_BASE, 5'd5, 5'd5, 3'b000, 5'd6));
        send_inst(enc_r(F7_MUL, 5'd6, 5'd6, 3'b000, 5'd7));
        send_inst(enc_r(F7_ALT, 5'd5, 5'd7, 3'b000, 5'd8));
        send_inst(enc_i(12'h001, 5'd8, 3'b000, 5'd9));
        send_inst(enc_r(F7_BASE, 5'd8, 5'd9, 3'b111, 5'd10));
        // Done entry waiting behind a slow MUL feeds the next add
        send_inst(enc_r(F7_MUL, 5'd1, 5'd1, 3'b000, 5'd12));
        send_inst(enc_i(12'h009, 5'd0, 3'b000, 5'd13));
        send_inst(enc_i(12'h001, 5'd13, 3'b000, 5'd14));
        send_inst(enc_r(F7_BASE, 5'd14, 5'd12, 3'b000, 5'd15));
        for (int i = 0; i < 24; i++) begin
            send_inst(random_inst());
        end
        drain_commits();
    endtask

    task automatic test_backpressure();
        core_pkg::inst_u blocked;
        commit_ready = 1'b0;
        for (int i = 1; i <= ROB_DEPTH; i++) begin
            send_inst(enc_i(12'(i * 37), 5'd0, 3'b000, 5'(i)));
        end
        // Buffer is full, so this word has to wait
        blocked = enc_r(F7_BASE, 5'd2, 5'd1, 3'b000, 5'd11);
        inst_valid = 1'b1;
        inst_data = blocked;
        repeat (3) begin
            @(posedge clk);
            check_bit("inst_ready", inst_ready, 1'b0);
            check_bit("commit_valid", commit_valid, 1'b1);
        end
        @(negedge clk);
        sending_done = 1'b0;
        fork
            begin
                send_inst(blocked);
                repeat (30) send_inst(random_inst());
                sending_done = 1'b1;
            end
            begin
                int stretch;
                stretch = 0;
                while (!sending_done || expected_q.size() != 0) begin
                    @(negedge clk);
                    if (stretch > 0) begin
                        commit_ready = 1'b0;
                        stretch--;
                    end else if ($urandom_range(2, 0) == 0) begin
                        commit_ready = 1'b0;
                        stretch = $urandom_range(7, 1);
                    end else begin
                        commit_ready = 1'b1;
                    end
                end
                commit_ready = 1'b1;
            end
        join
        drain_commits();
    endtask

    // Checks each retirement and the hold of an unaccepted commit
    always @(posedge clk) begin : commit_monitor
        core_pkg::commit_t exp;
        if (reset) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid && !commit_valid) begin
                errors++;
                $display("commit_valid dropped before its handshake at %0t", $time);
            end
            if (held_valid && commit_valid) begin
                check_commit("commit_data held", commit_data, held_data);
            end
            if (commit_valid && commit_ready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Commit seen with no instruction outstanding at %0t", $time);
                end else begin
                    exp = expected_q.pop_front();
                    check_commit("commit_data", commit_data, exp);
                end
                held_valid = 1'b0;
            end else begin
                held_valid = commit_valid;
                held_data = commit_data;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 20 * sent + 1000) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d instructions sent", cycles, sent);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        inst_valid = 1'b0;
        inst_data = '0;
        commit_ready = 1'b1;
        errors = 0;
        checks = 0;
        sent = 0;
        sending_done = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(59));
        wait (!reset);
        @(negedge clk);
        test_reset();
        test_alu_ops();
        test_mul_order();
        test_dependencies();
        test_backpressure();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Two rising edges see reset, release away from the edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== hw/core_top.sv ====
`timescale 1ns/10ps

module core_top #(
    parameter int ROB_DEPTH = 10,
    parameter int MUL_STAGES = 5
) (
    input logic clk,
    input logic reset,
    input logic inst_valid,
    input core_pkg::inst_u inst_data,
    output logic inst_ready,
    output logic commit_valid,
    output core_pkg::commit_t commit_data,
    input logic commit_ready
);

    logic [core_pkg::REG_ADDR_W-1:0] rs1;
    logic [core_pkg::REG_ADDR_W-1:0] rs2;
    logic [core_pkg::XLEN-1:0] rf_rs1_data;
    logic [core_pkg::XLEN-1:0] rf_rs2_data;
    core_pkg::operand_lookup_t lookup_rs1;
    core_pkg::operand_lookup_t lookup_rs2;
    core_pkg::rob_tag_t alloc_tag;
    logic rob_full;
    logic alloc_valid;
    logic [core_pkg::REG_ADDR_W-1:0] alloc_rd;
    logic alu_issue_valid;
    logic mul_issue_valid;
    core_pkg::issue_t issue;
    core_pkg::complete_t alu_complete;
    core_pkg::complete_t mul_complete;
    logic commit_fire;

    // Retirement writes the architectural state on the handshake edge
    assign commit_fire = commit_valid && commit_ready;

    decode_issue u_decode_issue (
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .inst_ready     (inst_ready),
        .rs1            (rs1),
        .rs2            (rs2),
        .rf_rs1_data    (rf_rs1_data),
        .rf_rs2_data    (rf_rs2_data),
        .lookup_rs1     (lookup_rs1),
        .lookup_rs2     (lookup_rs2),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .alloc_valid    (alloc_valid),
        .alloc_rd       (alloc_rd),
        .alu_issue_valid(alu_issue_valid),
        .mul_issue_valid(mul_issue_valid),
        .issue          (issue)
    );

    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_data  (rf_rs1_data),
        .rs2_data  (rf_rs2_data),
        .write_en  (commit_fire),
        .write_rd  (commit_data.rd),
        .write_data(commit_data.value)
    );

    alu_unit u_alu_unit (
        .clk        (clk),
        .reset      (reset),
        .issue_valid(alu_issue_valid),
        .issue      (issue),
        .complete   (alu_complete)
    );

    mul_pipeline #(
        .MUL_STAGES(MUL_STAGES)
    ) u_mul_pipeline (
        .clk        (clk),
        .reset      (reset),
        .issue_valid(mul_issue_valid),
        .issue      (issue),
        .complete   (mul_complete)
    );

    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_reorder_buffer (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .alloc_tag   (alloc_tag),
        .full        (rob_full),
        .alu_complete(alu_complete),
        .mul_complete(mul_complete),
        .rs1         (rs1),
        .rs2         (rs2),
        .lookup_rs1  (lookup_rs1),
        .lookup_rs2  (lookup_rs2),
        .commit_valid(commit_valid),
        .commit_data (commit_data),
        .commit_ready(commit_ready)
    );

endmodule

// ==== hw/decode_issue.sv ====
`timescale 1ns/10ps

module decode_issue (
    input logic inst_valid,
    input core_pkg::inst_u inst_data,
    output logic inst_ready,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2,
    input logic [core_pkg::XLEN-1:0] rf_rs1_data,
    input logic [core_pkg::XLEN-1:0] rf_rs2_data,
    input core_pkg::operand_lookup_t lookup_rs1,
    input core_pkg::operand_lookup_t lookup_rs2,
    input core_pkg::rob_tag_t alloc_tag,
    input logic rob_full,
    output logic alloc_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] alloc_rd,
    output logic alu_issue_valid,
    output logic mul_issue_valid,
    output core_pkg::issue_t issue
);

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    logic is_op;
    logic is_op_imm;
    logic is_mul;
    logic supported;
    logic alt;
    logic is_shift;
    logic pending;
    logic stall;
    logic fire;
    core_pkg::alu_op_e alu_op;
    logic [core_pkg::XLEN-1:0] imm_ext;
    logic [core_pkg::XLEN-1:0] operand_a;
    logic [core_pkg::XLEN-1:0] src_b;
    logic [core_pkg::XLEN-1:0] raw_b;
    logic [core_pkg::XLEN-1:0] operand_b;

    assign is_op = inst_data.r.opcode == core_pkg::OPCODE_OP;
    assign is_op_imm = inst_data.i.opcode == core_pkg::OPCODE_OP_IMM;
    assign is_mul = is_op && inst_data.r.funct7 == FUNCT7_MULDIV && inst_data.r.funct3 == 3'b000;
    // Other M extension ops are dropped like foreign opcodes
    assign supported = is_op_imm || (is_op && (inst_data.r.funct7 != FUNCT7_MULDIV || is_mul));

    // SUB and SRA select bit sits at the same position in both views
    assign alt = inst_data.r.funct7[5];

    always_comb begin
        case (inst_data.r.funct3)
            3'b000: alu_op = (is_op && alt) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001: alu_op = core_pkg::ALU_SLL;
            3'b010: alu_op = core_pkg::ALU_SLT;
            3'b011: alu_op = core_pkg::ALU_SLTU;
            3'b100: alu_op = core_pkg::ALU_XOR;
            3'b101: alu_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110: alu_op = core_pkg::ALU_OR;
            default: alu_op = core_pkg::ALU_AND;
        endcase
    end

    assign is_shift = inst_data.r.funct3 == 3'b001 || inst_data.r.funct3 == 3'b101;

    // Immediate forms read no rs2, so it is parked on x0
    assign rs1 = inst_data.r.rs1;
    assign rs2 = is_op ? inst_data.r.rs2 : '0;

    assign operand_a = lookup_rs1.hit ? lookup_rs1.value : rf_rs1_data;
    assign src_b = lookup_rs2.hit ? lookup_rs2.value : rf_rs2_data;
    assign imm_ext = {{(core_pkg::XLEN-12){inst_data.i.imm[11]}}, inst_data.i.imm};
    assign raw_b = is_op_imm ? imm_ext : src_b;
    assign operand_b = is_shift ? {{(core_pkg::XLEN-5){1'b0}}, raw_b[4:0]} : raw_b;

    // Wait for producers still in flight
    assign pending = (lookup_rs1.hit && !lookup_rs1.done) || (lookup_rs2.hit && !lookup_rs2.done);
    assign stall = supported && (rob_full || pending);
    assign inst_ready = !stall;
    assign fire = inst_valid && supported && !stall;

    assign alloc_valid = fire;
    assign alloc_rd = inst_data.r.rd;
    assign alu_issue_valid = fire && !is_mul;
    assign mul_issue_valid = fire && is_mul;

    assign issue = '{tag: alloc_tag, op: alu_op, a: operand_a, b: operand_b};

endmodule

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 10
) (
    input logic clk,
    input logic reset,
    input logic alloc_valid,
    input logic [core_pkg::REG_ADDR_W-1:0] alloc_rd,
    output core_pkg::rob_tag_t alloc_tag,
    output logic full,
    input core_pkg::complete_t alu_complete,
    input core_pkg::complete_t mul_complete,
    input logic [core_pkg::REG_ADDR_W-1:0] rs1,
    input logic [core_pkg::REG_ADDR_W-1:0] rs2,
    output core_pkg::operand_lookup_t lookup_rs1,
    output core_pkg::operand_lookup_t lookup_rs2,
    output logic commit_valid,
    output core_pkg::commit_t commit_data,
    input logic commit_ready
);

    localparam int COUNT_W = $clog2(ROB_DEPTH + 1);

    typedef struct packed {
        logic busy;
        logic done;
        logic [core_pkg::REG_ADDR_W-1:0] rd;
        logic [core_pkg::XLEN-1:0] value;
    } entry_t;

    entry_t entries [ROB_DEPTH];
    core_pkg::rob_tag_t head;
    core_pkg::rob_tag_t tail;
    logic [COUNT_W-1:0] count;
    logic commit_fire;

    function automatic core_pkg::rob_tag_t next_ptr(input core_pkg::rob_tag_t ptr);
        if (ptr == core_pkg::rob_tag_t'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Walk from oldest to youngest, so the last match wins
    function automatic core_pkg::operand_lookup_t find_src(
        input logic [core_pkg::REG_ADDR_W-1:0] rs
    );
        core_pkg::operand_lookup_t res;
        int pos;
        res = '0;
        for (int k = 0; k < ROB_DEPTH; k++) begin
            pos = int'(head) + k;
            if (pos >= ROB_DEPTH) begin
                pos = pos - ROB_DEPTH;
            end
            if (rs != '0 && entries[pos].busy && entries[pos].rd == rs) begin
                res.hit = 1'b1;
                res.done = entries[pos].done;
                res.value = entries[pos].value;
            end
        end
        return res;
    endfunction

    assign alloc_tag = tail;
    assign full = (count == COUNT_W'(ROB_DEPTH));

    assign lookup_rs1 = find_src(rs1);
    assign lookup_rs2 = find_src(rs2);

    // Head retires only once its result is in
    assign commit_valid = entries[head].busy && entries[head].done;
    assign commit_data = '{rd: entries[head].rd, value: entries[head].value};
    assign commit_fire = commit_valid && commit_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            // Both units may finish in the same cycle on different tags
            if (alu_complete.valid) begin
                entries[alu_complete.tag].done <= 1'b1;
                entries[alu_complete.tag].value <= alu_complete.value;
            end
            if (mul_complete.valid) begin
                entries[mul_complete.tag].done <= 1'b1;
                entries[mul_complete.tag].value <= mul_complete.value;
            end

            if (alloc_valid) begin
                entries[tail].busy <= 1'b1;
                entries[tail].done <= 1'b0;
                entries[tail].rd <= alloc_rd;
                tail <= next_ptr(tail);
            end

            if (commit_fire) begin
                entries[head].busy <= 1'b0;
                entries[head].done <= 1'b0;
                head <= next_ptr(head);
            end

            case ({alloc_valid, commit_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/mul_pipeline.sv ====
`timescale 1ns/10ps

module mul_pipeline #(
    parameter int MUL_STAGES = 5
) (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input core_pkg::issue_t issue,
    output core_pkg::complete_t complete
);

    logic [core_pkg::XLEN-1:0] product;
    logic [MUL_STAGES-1:0] stage_valid;
    core_pkg::rob_tag_t stage_tag [MUL_STAGES];
    logic [core_pkg::XLEN-1:0] stage_value [MUL_STAGES];

    // Low word only, so signedness of the operands does not matter
    assign product = issue.a * issue.b;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue_valid;
            for (int s = 1; s < MUL_STAGES; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    // Payload shifts every cycle, one item per stage
    always_ff @(posedge clk) begin
        stage_tag[0] <= issue.tag;
        stage_value[0] <= product;
        for (int s = 1; s < MUL_STAGES; s++) begin
            stage_tag[s] <= stage_tag[s-1];
            stage_value[s] <= stage_value[s-1];
        end
    end

    assign complete = '{
        valid: stage_valid[MUL_STAGES-1],
        tag: stage_tag[MUL_STAGES-1],
        value: stage_value[MUL_STAGES-1]
    };

endmodule

// ==== hw/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input core_pkg::issue_t issue,
    output core_pkg::complete_t complete
);

    logic [core_pkg::XLEN-1:0] result;
    logic [4:0] shamt;

    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.op)
            core_pkg::ALU_ADD: result = issue.a + issue.b;
            core_pkg::ALU_SUB: result = issue.a - issue.b;
            core_pkg::ALU_AND: result = issue.a & issue.b;
            core_pkg::ALU_OR: result = issue.a | issue.b;
            core_pkg::ALU_XOR: result = issue.a ^ issue.b;
            core_pkg::ALU_SLT: begin
                result = {{(core_pkg::XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
            end
            core_pkg::ALU_SLTU: begin
                result = {{(core_pkg::XLEN-1){1'b0}}, issue.a < issue.b};
            end
            core_pkg::ALU_SLL: result = issue.a << shamt;
            core_pkg::ALU_SRL: result = issue.a >> shamt;
            core_pkg::ALU_SRA: result = $unsigned($signed(issue.a) >>> shamt);
            default: result = '0;
        endcase
    end

    // Single result register towards the reorder buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            complete.valid <= 1'b0;
        end else begin
            complete.valid <= issue_valid;
        end
        complete.tag <= issue.tag;
        complete.value <= result;
    end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input logic clk,
    input logic reset,
    input logic [core_pkg::REG_ADDR_W-1:0] rs1,
    input logic [core_pkg::REG_ADDR_W-1:0] rs2,
    output logic [core_pkg::XLEN-1:0] rs1_data,
    output logic [core_pkg::XLEN-1:0] rs2_data,
    input logic write_en,
    input logic [core_pkg::REG_ADDR_W-1:0] write_rd,
    input logic [core_pkg::XLEN-1:0] write_data
);

    logic [core_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_rd != '0) begin
            regs[write_rd] <= write_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

    // Datapath and index widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_TAG_W = 4;

    // Only integer register and immediate ops are executed
    localparam logic [6:0] OPCODE_OP = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // R format view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // I format view
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Operation handed to an execution unit
    typedef struct packed {
        rob_tag_t tag;
        alu_op_e op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } issue_t;

    typedef struct packed {
        logic valid;
        rob_tag_t tag;
        logic [XLEN-1:0] value;
    } complete_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0] value;
    } commit_t;

    // hit means an older buffer entry will write this register
    typedef struct packed {
        logic hit;
        logic done;
        logic [XLEN-1:0] value;
    } operand_lookup_t;

endpackage
